// ==== list.f ====
xbar_pkg.sv
xbar_ifs.sv
command_stage.sv
bitplane_gather.sv
activation_stage.sv
row_assembler.sv
xbar_postproc.sv
xbar_postproc_assertions.sv
tb_xbar_postproc.sv

// ==== Makefile ====
TOP = tb_xbar_postproc

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing --assert -f list.f --top-module $(TOP)

sim:
	verilator --binary --timing --assert -f list.f --top-module $(TOP)
	./obj_dir/V$(TOP) > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "TESTBENCH FAILED" sim.log; then exit 1; fi
	@grep -q "TESTBENCH PASSED" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== tb_xbar_postproc.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// testbench for the crossbar post-processing pipeline
// clock, reset, reference model of activation and row placement,
// directed tests, compare tasks and cycle limit
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module tb_xbar_postproc;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int N_ROWS     = 16;
  localparam int VEC_W      = N_ROWS * xbar_pkg::COLS;
  localparam int VEC_LAT    = 6;    // falling edges from command drive to vec_valid
  localparam int MAX_CYCLES = 400;

  typedef logic [xbar_pkg::COLS-1:0][xbar_pkg::SUM_BITS-1:0] sums_t;

  logic                        CLK;
  logic                        RESET_INsig;
  logic                        cmd_valid;
  logic [xbar_pkg::OP_W-1:0]   cmd_op;
  logic [xbar_pkg::ID_W-1:0]   cmd_id;
  logic [xbar_pkg::ROW_W-1:0]  cmd_row;
  logic [xbar_pkg::THR_W-1:0]  cmd_threshold;
  logic [xbar_pkg::SEL_W-1:0]  cmd_xbar_sel;
  logic                        pos_sense;
  logic                        neg_sense;
  logic [xbar_pkg::COLS-1:0]   pos_plane;
  logic [xbar_pkg::COLS-1:0]   neg_plane;
  logic                        read_valid;
  logic                        read_data;
  logic                        write_ack;
  logic [xbar_pkg::ID_W-1:0]   out_id;
  logic [VEC_W-1:0]            out_vector;
  logic                        vec_valid;
  logic                        vec_done;

  // planes waiting for the crossbar side, and results still in flight
  logic [xbar_pkg::COLS-1:0]   pos_planes_q [$];
  logic [xbar_pkg::COLS-1:0]   neg_planes_q [$];
  int                          due_q [$];
  logic [xbar_pkg::ID_W-1:0]   due_id_q [$];
  logic [xbar_pkg::ROW_W-1:0]  due_row_q [$];
  logic [xbar_pkg::COLS-1:0]   due_bits_q [$];

  logic [VEC_W-1:0]            model_vec;
  logic [xbar_pkg::ID_W-1:0]   model_id;
  logic                        model_done;
  logic                        rd_due;
  logic                        rd_exp;
  logic                        wr_due;
  int                          cycle_cnt = 0;
  integer                      seed = 63;

  xbar_postproc #(
    .N_ROWS (N_ROWS)
  ) u_xbar_postproc (
    .CLK           (CLK),
    .RESET_INsig   (RESET_INsig),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_id        (cmd_id),
    .cmd_row       (cmd_row),
    .cmd_threshold (cmd_threshold),
    .cmd_xbar_sel  (cmd_xbar_sel),
    .pos_sense     (pos_sense),
    .neg_sense     (neg_sense),
    .pos_plane     (pos_plane),
    .neg_plane     (neg_plane),
    .read_valid    (read_valid),
    .read_data     (read_data),
    .write_ack     (write_ack),
    .out_id        (out_id),
    .out_vector    (out_vector),
    .vec_valid     (vec_valid),
    .vec_done      (vec_done)
  );

  bind xbar_postproc xbar_postproc_assertions u_assertions (
    .CLK         (CLK),
    .RESET_INsig (RESET_INsig),
    .cmd_valid   (cmd_valid),
    .cmd_op      (cmd_op),
    .write_ack   (write_ack),
    .vec_valid   (vec_valid),
    .vec_done    (vec_done)
  );

  initial
  begin
    CLK = 1'b0;
    forever #10 CLK = ~CLK;
  end

  always @(posedge CLK)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
      abort_run($sformatf("timeout, tests still running after %0d cycles", MAX_CYCLES));
  end

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("TESTBENCH FAILED");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic check_vector(
    input logic [VEC_W-1:0]          got_vec,
    input logic [VEC_W-1:0]          exp_vec,
    input logic [xbar_pkg::ID_W-1:0] got_id,
    input logic [xbar_pkg::ID_W-1:0] exp_id,
    input string                     what
  );
    if (got_vec !== exp_vec || got_id !== exp_id)
      abort_run($sformatf("mismatch at %0t: %s id %h vector %h, expected id %h vector %h",
                          $time, what, got_id, got_vec, exp_id, exp_vec));
  endtask

  task automatic check_bit(input logic got, input logic expected, input string what);
    if (got !== expected)
      abort_run($sformatf("mismatch at %0t: %s is %b, expected %b",
                          $time, what, got, expected));
  endtask

  task automatic check_flag(input logic got, input logic expected, input string what);
    if (expected && got !== 1'b1)
      abort_run($sformatf("%s did not go high when expected at time %0t", what, $time));
    else if (!expected && got !== 1'b0)
      abort_run($sformatf("mismatch at %0t: %s is high, expected low", $time, what));
  endtask

  // activation rule: pos - neg against the sign-magnitude threshold, ties fire
  function automatic logic [xbar_pkg::COLS-1:0] expected_act(
    input sums_t ps, input sums_t ns, input logic [xbar_pkg::THR_W-1:0] thr);
    int                        t;
    int                        d;
    logic [xbar_pkg::COLS-1:0] b;
    t = int'(thr[2:0]);
    if (thr[3])
      t = -t;
    for (int c = 0; c < xbar_pkg::COLS; c++)
    begin
      d = int'(ps[c]) - int'(ns[c]);
      b[c] = (d >= t);
    end
    return b;
  endfunction

  // one falling edge: check what landed, then drive the idle command and planes
  task automatic next_cycle();
    logic [xbar_pkg::ID_W-1:0]  id;
    logic [xbar_pkg::ROW_W-1:0] row;
    logic                       landing;
    @(negedge CLK);
    landing = 1'b0;
    if (due_q.size() > 0)
      landing = (due_q[0] == cycle_cnt);
    check_flag(vec_valid, landing, "vec_valid");
    if (landing)
    begin
      id  = due_id_q.pop_front();
      row = due_row_q.pop_front();
      due_q.delete(0);
      if (id != model_id)
        model_vec = '0;  // new layer starts blank
      model_vec[int'(row)*xbar_pkg::COLS +: xbar_pkg::COLS] = due_bits_q.pop_front();
      model_id   = id;
      model_done = (int'(row) == N_ROWS - 1);
      check_vector(out_vector, model_vec, out_id, model_id, "layer vector");
    end
    check_flag(vec_done, model_done, "vec_done");
    check_flag(read_valid, rd_due, "read_valid");
    if (rd_due)
      check_bit(read_data, rd_exp, "read_data");
    check_flag(write_ack, wr_due, "write_ack");
    rd_due    = 1'b0;
    wr_due    = 1'b0;
    cmd_valid = 1'b0;
    cmd_op    = xbar_pkg::OP_SLEEP;
    pos_plane = '0;
    neg_plane = '0;
    if (pos_planes_q.size() > 0)
    begin
      pos_plane = pos_planes_q.pop_front();
      neg_plane = neg_planes_q.pop_front();
    end
  endtask

  task automatic issue_compute(input logic [xbar_pkg::ID_W-1:0] id,
                               input logic [xbar_pkg::ROW_W-1:0] row,
                               input logic [xbar_pkg::THR_W-1:0] thr,
                               input sums_t ps, input sums_t ns);
    logic [xbar_pkg::COLS-1:0] pp;
    logic [xbar_pkg::COLS-1:0] np;
    cmd_valid     = 1'b1;
    cmd_op        = xbar_pkg::OP_COMPUTE;
    cmd_id        = id;
    cmd_row       = row;
    cmd_threshold = thr;
    for (int p = 0; p < xbar_pkg::SUM_BITS; p++)
    begin
      for (int c = 0; c < xbar_pkg::COLS; c++)
      begin
        pp[c] = ps[c][p];  // lsb plane first
        np[c] = ns[c][p];
      end
      pos_planes_q.push_back(pp);
      neg_planes_q.push_back(np);
    end
    due_q.push_back(cycle_cnt + VEC_LAT);
    due_id_q.push_back(id);
    due_row_q.push_back(row);
    due_bits_q.push_back(expected_act(ps, ns, thr));
  endtask

  task automatic request_read(input logic [xbar_pkg::SEL_W-1:0] sel,
                              input logic ps, input logic ns);
    cmd_valid    = 1'b1;
    cmd_op       = xbar_pkg::OP_READ;
    cmd_xbar_sel = sel;
    pos_sense    = ps;
    neg_sense    = ns;
    rd_due       = 1'b1;
    case (sel)
      2'd0:    rd_exp = ps;
      2'd1:    rd_exp = ns;
      default: rd_exp = 1'b0;
    endcase
  endtask

  task automatic request_write();
    cmd_valid = 1'b1;
    cmd_op    = xbar_pkg::OP_WRITE;
    wr_due    = 1'b1;
  endtask

  task automatic wait_pipeline_empty();
    while (due_q.size() > 0 || pos_planes_q.size() > 0)
      next_cycle();
  endtask

  function automatic sums_t random_sums();
    sums_t s;
    for (int c = 0; c < xbar_pkg::COLS; c++)
      s[c] = 3'($random(seed));
    return s;
  endfunction

  task automatic reset_state_checks();
    check_vector(out_vector, '0, out_id, '0, "vector after reset");
    check_bit(read_data, 1'b0, "read_data after reset");
    check_flag(read_valid, 1'b0, "read_valid after reset");
    check_flag(write_ack, 1'b0, "write_ack after reset");
    check_flag(vec_valid, 1'b0, "vec_valid after reset");
    check_flag(vec_done, 1'b0, "vec_done after reset");
    next_cycle();
    next_cycle();
  endtask

  task automatic read_write_access();
    for (int i = 0; i < 8; i++)
    begin
      next_cycle();
      request_read(2'(i), 1'($random(seed)), 1'($random(seed)));
      next_cycle();
      request_write();
    end
    // reads while a gather is running
    next_cycle();
    issue_compute(8'h11, 4'd3, 4'b0001, random_sums(), random_sums());
    next_cycle();
    request_read(2'd0, 1'b1, 1'b0);
    next_cycle();
    request_read(2'd1, 1'b0, 1'b1);
    wait_pipeline_empty();
  endtask

  task automatic single_row_activation();
    sums_t p;
    sums_t n;
    // column diffs 3, 0, 0, -3
    p = {3'd1, 3'd0, 3'd7, 3'd5};
    n = {3'd4, 3'd0, 3'd7, 3'd2};
    next_cycle();
    issue_compute(8'h3C, 4'd2, 4'b0011, p, n);  // tie at +3
    wait_pipeline_empty();
    next_cycle();
    issue_compute(8'h3C, 4'd9, 4'b1011, p, n);  // tie at -3
    wait_pipeline_empty();
    next_cycle();
    issue_compute(8'h3C, 4'd4, 4'b1000, p, n);  // negative zero
    wait_pipeline_empty();
    for (int i = 0; i < 12; i++)
    begin
      next_cycle();
      issue_compute(8'h3C, 4'($random(seed)), 4'($random(seed)),
                    random_sums(), random_sums());
      wait_pipeline_empty();
    end
  endtask

  task automatic full_layer_burst();
    for (int r = 0; r < N_ROWS; r++)
    begin
      next_cycle();
      issue_compute(8'h5A, 4'(r), 4'($random(seed)), random_sums(), random_sums());
      next_cycle();
      next_cycle();
    end
    wait_pipeline_empty();
    check_flag(vec_done, 1'b1, "vec_done after the last row");
  endtask

  task automatic new_layer_id();
    sums_t                     p;
    sums_t                     n;
    logic [VEC_W-1:0]          exp_vec;
    p = {3'd7, 3'd3, 3'd0, 3'd6};
    n = {3'd0, 3'd3, 3'd5, 3'd1};
    next_cycle();
    issue_compute(8'hA7, 4'd6, 4'b0010, p, n);
    wait_pipeline_empty();
    exp_vec = '0;
    exp_vec[6*xbar_pkg::COLS +: xbar_pkg::COLS] = expected_act(p, n, 4'b0010);
    check_vector(out_vector, exp_vec, out_id, 8'hA7, "vector after new id");
  endtask

  initial
  begin
    RESET_INsig   = 1'b1;
    cmd_valid     = 1'b0;
    cmd_op        = xbar_pkg::OP_SLEEP;
    cmd_id        = '0;
    cmd_row       = '0;
    cmd_threshold = '0;
    cmd_xbar_sel  = '0;
    pos_sense     = 1'b0;
    neg_sense     = 1'b0;
    pos_plane     = '0;
    neg_plane     = '0;
    model_vec     = '0;
    model_id      = '0;
    model_done    = 1'b0;
    rd_due        = 1'b0;
    rd_exp        = 1'b0;
    wr_due        = 1'b0;
    repeat (4) @(posedge CLK);
    @(negedge CLK);
    RESET_INsig = 1'b0;
    reset_state_checks();
    read_write_access();
    single_row_activation();
    full_layer_burst();
    new_layer_id();
    next_cycle();
    $display("TESTBENCH PASSED");
    $finish;
  end

endmodule

`default_nettype wire

// ==== xbar_postproc_assertions.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// concurrent checks on top-level command and result timing
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xbar_postproc_assertions (
  input logic                       CLK,
  input logic                       RESET_INsig,
  input logic                       cmd_valid,
  input logic [xbar_pkg::OP_W-1:0]  cmd_op,
  input logic                       write_ack,
  input logic                       vec_valid,
  input logic                       vec_done
);
  timeunit 1ns;
  timeprecision 100ps;

  logic is_compute;
  logic is_write;

  assign is_compute = cmd_valid && (cmd_op == xbar_pkg::OP_COMPUTE);
  assign is_write   = cmd_valid && (cmd_op == xbar_pkg::OP_WRITE);

  // gather is busy for three cycles
  compute_spacing: assert property (@(posedge CLK) disable iff (RESET_INsig)
    is_compute |-> !$past(is_compute) && !$past(is_compute, 2))
    else $error("compute command inside the gather window");

  // command edge plus five, seen on the following edge
  compute_latency: assert property (@(posedge CLK) disable iff (RESET_INsig)
    $past(is_compute, 6) |-> vec_valid)
    else $error("vec_valid missing after a compute command");

  write_response: assert property (@(posedge CLK) disable iff (RESET_INsig)
    is_write |=> write_ack)
    else $error("write_ack missing after a write command");

  done_with_valid: assert property (@(posedge CLK) disable iff (RESET_INsig)
    $rose(vec_done) |-> vec_valid)
    else $error("vec_done rose without vec_valid");

endmodule

`default_nettype wire

// ==== xbar_postproc.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// crossbar post-processing top level
// command stage, bit-plane gather, activation and row assembly
// joined by the stage interfaces
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module xbar_postproc #(
  parameter int N_ROWS = 16
) (
  input  logic                              CLK,
  input  logic                              RESET_INsig,

  // host command
  input  logic                              cmd_valid,
  input  logic [xbar_pkg::OP_W-1:0]         cmd_op,
  input  logic [xbar_pkg::ID_W-1:0]         cmd_id,
  input  logic [xbar_pkg::ROW_W-1:0]        cmd_row,
  input  logic [xbar_pkg::THR_W-1:0]        cmd_threshold,
  input  logic [xbar_pkg::SEL_W-1:0]        cmd_xbar_sel,

  // crossbar side
  input  logic                              pos_sense,
  input  logic                              neg_sense,
  input  logic [xbar_pkg::COLS-1:0]         pos_plane,
  input  logic [xbar_pkg::COLS-1:0]         neg_plane,

  output logic                              read_valid,
  output logic                              read_data,
  output logic                              write_ack,
  output logic [xbar_pkg::ID_W-1:0]         out_id,
  output logic [N_ROWS*xbar_pkg::COLS-1:0]  out_vector,
  output logic                              vec_valid,
  output logic                              vec_done
);

  compute_if u_cmp_if ();
  colsum_if  u_cs_if ();
  act_if     u_act_if ();

  command_stage u_command_stage (
    .CLK           (CLK),
    .RESET_INsig   (RESET_INsig),
    .cmd_valid     (cmd_valid),
    .cmd_op        (cmd_op),
    .cmd_id        (cmd_id),
    .cmd_row       (cmd_row),
    .cmd_threshold (cmd_threshold),
    .cmd_xbar_sel  (cmd_xbar_sel),
    .pos_sense     (pos_sense),
    .neg_sense     (neg_sense),
    .read_valid    (read_valid),
    .read_data     (read_data),
    .write_ack     (write_ack),
    .cmp           (u_cmp_if.src)
  );

  // planes arrive the three cycles after the command cycle
  bitplane_gather u_bitplane_gather (
    .CLK         (CLK),
    .RESET_INsig (RESET_INsig),
    .pos_plane   (pos_plane),
    .neg_plane   (neg_plane),
    .cmp         (u_cmp_if.dst),
    .cs          (u_cs_if.src)
  );

  activation_stage u_activation_stage (
    .CLK         (CLK),
    .RESET_INsig (RESET_INsig),
    .cs          (u_cs_if.dst),
    .act         (u_act_if.src)
  );

  row_assembler #(
    .N_ROWS (N_ROWS)
  ) u_row_assembler (
    .CLK         (CLK),
    .RESET_INsig (RESET_INsig),
    .out_id      (out_id),
    .out_vector  (out_vector),
    .vec_valid   (vec_valid),
    .vec_done    (vec_done),
    .act         (u_act_if.dst)
  );

endmodule

`default_nettype wire

// ==== row_assembler.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// layer vector assembly
// drops each row's activation bits into its slot, starts a fresh
// vector on a new layer id and flags the last row
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module row_assembler #(
  parameter int N_ROWS = 16
) (
  input  logic                              CLK,
  input  logic                              RESET_INsig,
  output logic [xbar_pkg::ID_W-1:0]         out_id,
  output logic [N_ROWS*xbar_pkg::COLS-1:0]  out_vector,
  output logic                              vec_valid,
  output logic                              vec_done,
  act_if.dst                                act
);

  localparam int VEC_W = N_ROWS * xbar_pkg::COLS;
  localparam logic [xbar_pkg::ROW_W-1:0] LAST_ROW = xbar_pkg::ROW_W'(N_ROWS - 1);

  logic             new_layer;
  logic             last_row;
  logic [VEC_W-1:0] next_vector;

  assign new_layer = (act.id != out_id);
  assign last_row  = (act.row == LAST_ROW);

  // old vector or blank, then the row slot on top
  always_comb
  begin
    next_vector = new_layer ? '0 : out_vector;
    next_vector[int'(act.row)*xbar_pkg::COLS +: xbar_pkg::COLS] = act.act_bits;
  end

  always_ff @(posedge CLK)
  begin
    if (RESET_INsig)
    begin
      out_id     <= '0;
      out_vector <= '0;
      vec_valid  <= 1'b0;
      vec_done   <= 1'b0;
    end
    else
    begin
      vec_valid <= act.valid;
      if (act.valid)
      begin
        out_id     <= act.id;
        out_vector <= next_vector;
        vec_done   <= last_row;  // stays until the next item
      end
    end
  end

endmodule

`default_nettype wire

// ==== activation_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// threshold activation
// per column difference pos - neg compared with a signed threshold
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module activation_stage (
  input  logic     CLK,
  input  logic     RESET_INsig,
  colsum_if.dst    cs,
  act_if.src       act
);

  localparam int DIFF_W = xbar_pkg::SUM_BITS + 1;   // -7 .. +7
  localparam int MAG_W  = xbar_pkg::THR_W - 1;

  logic signed [DIFF_W-1:0]          diff [xbar_pkg::COLS];
  logic signed [xbar_pkg::THR_W-1:0] thr_s;
  logic [MAG_W-1:0]                  thr_mag;
  logic [xbar_pkg::COLS-1:0]         fire;

  always_comb
  begin
    for (int c = 0; c < xbar_pkg::COLS; c++)
    begin
      diff[c] = $signed({1'b0, cs.pos.cols[c]}) - $signed({1'b0, cs.neg.cols[c]});
    end
  end

  // sign-magnitude to two's complement, -0 folds onto 0
  assign thr_mag = cs.threshold[MAG_W-1:0];
  assign thr_s   = cs.threshold[xbar_pkg::THR_W-1] ? -$signed({1'b0, thr_mag})
                                                   :  $signed({1'b0, thr_mag});

  always_comb
  begin
    for (int c = 0; c < xbar_pkg::COLS; c++)
    begin
      fire[c] = (diff[c] >= thr_s);  // ties fire
    end
  end

  always_ff @(posedge CLK)
  begin
    if (RESET_INsig)
      act.valid <= 1'b0;
    else
      act.valid <= cs.valid;
  end

  always_ff @(posedge CLK)
  begin
    if (cs.valid)
    begin
      act.id       <= cs.id;
      act.row      <= cs.row;
      act.act_bits <= fire;
    end
  end

endmodule

`default_nettype wire

// ==== bitplane_gather.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// bit-plane gather
// collects SUM_BITS planes of the positive and negative column sums
// for one compute item, lsb plane first, then hands the item on
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module bitplane_gather (
  input  logic                          CLK,
  input  logic                          RESET_INsig,
  input  logic [xbar_pkg::COLS-1:0]     pos_plane,
  input  logic [xbar_pkg::COLS-1:0]     neg_plane,
  compute_if.dst                        cmp,
  colsum_if.src                         cs
);

  localparam int CNT_W = $clog2(xbar_pkg::SUM_BITS);
  localparam logic [CNT_W-1:0] LAST_PLANE = CNT_W'(xbar_pkg::SUM_BITS - 1);

  logic                          busy;
  logic [CNT_W-1:0]              plane_cnt;   // next plane to take
  logic [CNT_W-1:0]              plane_idx;
  logic                          take_plane;
  logic                          done_q;
  xbar_pkg::colsum_u             pos_q;
  xbar_pkg::colsum_u             neg_q;
  logic [xbar_pkg::ID_W-1:0]     id_q;
  logic [xbar_pkg::ROW_W-1:0]    row_q;
  logic [xbar_pkg::THR_W-1:0]    thr_q;

  // plane 0 arrives together with the item
  assign take_plane = cmp.valid | busy;
  assign plane_idx  = cmp.valid ? '0 : plane_cnt;

  always_ff @(posedge CLK)
  begin
    if (RESET_INsig)
    begin
      busy      <= 1'b0;
      plane_cnt <= '0;
      done_q    <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      if (cmp.valid)
      begin
        busy      <= 1'b1;
        plane_cnt <= CNT_W'(1);
      end
      else if (busy)
      begin
        if (plane_cnt == LAST_PLANE)
        begin
          busy      <= 1'b0;
          plane_cnt <= '0;
          done_q    <= 1'b1;
        end
        else
          plane_cnt <= plane_cnt + 1'b1;
      end
    end
  end

  always_ff @(posedge CLK)
  begin
    if (cmp.valid)
    begin
      id_q  <= cmp.id;
      row_q <= cmp.row;
      thr_q <= cmp.threshold;
    end
    if (take_plane)
    begin
      // interleaved placement, column c plane p -> bit c*SUM_BITS+p
      for (int c = 0; c < xbar_pkg::COLS; c++)
      begin
        pos_q.flat[c*xbar_pkg::SUM_BITS + int'(plane_idx)] <= pos_plane[c];
        neg_q.flat[c*xbar_pkg::SUM_BITS + int'(plane_idx)] <= neg_plane[c];
      end
    end
  end

  assign cs.valid     = done_q;
  assign cs.id        = id_q;
  assign cs.row       = row_q;
  assign cs.threshold = thr_q;
  assign cs.pos       = pos_q;
  assign cs.neg       = neg_q;

endmodule

`default_nettype wire

// ==== command_stage.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// command register and decode
// READ samples one sense bit, WRITE is acked, COMPUTE starts an item
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

module command_stage (
  input  logic                           CLK,
  input  logic                           RESET_INsig,
  input  logic                           cmd_valid,
  input  logic [xbar_pkg::OP_W-1:0]      cmd_op,
  input  logic [xbar_pkg::ID_W-1:0]      cmd_id,
  input  logic [xbar_pkg::ROW_W-1:0]     cmd_row,
  input  logic [xbar_pkg::THR_W-1:0]     cmd_threshold,
  input  logic [xbar_pkg::SEL_W-1:0]     cmd_xbar_sel,
  input  logic                           pos_sense,
  input  logic                           neg_sense,
  output logic                           read_valid,
  output logic                           read_data,
  output logic                           write_ack,
  compute_if.src                         cmp
);

  logic is_read;
  logic is_write;
  logic is_compute;
  logic sense_sel;

  assign is_read    = cmd_valid && (cmd_op == xbar_pkg::OP_READ);
  assign is_write   = cmd_valid && (cmd_op == xbar_pkg::OP_WRITE);
  assign is_compute = cmd_valid && (cmd_op == xbar_pkg::OP_COMPUTE);

  always_comb
  begin
    case (cmd_xbar_sel)
      xbar_pkg::SEL_POS: sense_sel = pos_sense;
      xbar_pkg::SEL_NEG: sense_sel = neg_sense;
      default:           sense_sel = 1'b0;  // unused selects read zero
    endcase
  end

  always_ff @(posedge CLK)
  begin
    if (RESET_INsig)
    begin
      read_valid <= 1'b0;
      read_data  <= 1'b0;
      write_ack  <= 1'b0;
      cmp.valid  <= 1'b0;
    end
    else
    begin
      read_valid <= is_read;
      write_ack  <= is_write;
      cmp.valid  <= is_compute;
      if (is_read)
        read_data <= sense_sel;  // held until the next READ
    end
  end

  // item payload, only looked at with cmp.valid
  always_ff @(posedge CLK)
  begin
    if (is_compute)
    begin
      cmp.id        <= cmd_id;
      cmp.row       <= cmd_row;
      cmp.threshold <= cmd_threshold;
    end
  end

endmodule

`default_nettype wire

// ==== xbar_ifs.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// stage-to-stage interfaces of the post-processing pipeline
// compute_if  command stage to bit-plane gather
// colsum_if   gather to activation
// act_if      activation to row assembly
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

// one-cycle valid, payload only meaningful with valid high
interface compute_if;
  logic                         valid;
  logic [xbar_pkg::ID_W-1:0]    id;
  logic [xbar_pkg::ROW_W-1:0]   row;
  logic [xbar_pkg::THR_W-1:0]   threshold;

  modport src (output valid, output id, output row, output threshold);
  modport dst (input valid, input id, input row, input threshold);
endinterface

interface colsum_if;
  logic                         valid;
  logic [xbar_pkg::ID_W-1:0]    id;
  logic [xbar_pkg::ROW_W-1:0]   row;
  logic [xbar_pkg::THR_W-1:0]   threshold;
  xbar_pkg::colsum_u            pos;  // positive crossbar sums
  xbar_pkg::colsum_u            neg;  // negative crossbar sums

  modport src (
    output valid, output id, output row, output threshold,
    output pos, output neg
  );
  modport dst (
    input valid, input id, input row, input threshold,
    input pos, input neg
  );
endinterface

interface act_if;
  logic                         valid;
  logic [xbar_pkg::ID_W-1:0]    id;
  logic [xbar_pkg::ROW_W-1:0]   row;
  logic [xbar_pkg::COLS-1:0]    act_bits;  // bit c is column c

  modport src (output valid, output id, output row, output act_bits);
  modport dst (input valid, input id, input row, input act_bits);
endinterface

`default_nettype wire

// ==== xbar_pkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// shared definitions for the crossbar post-processing pipeline
// command opcodes, field widths, crossbar select codes
// column-sum word with its bit-plane and per-column views
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
`default_nettype none

package xbar_pkg;

  localparam int OP_W = 2;

  // command opcodes, same encoding as the front end uses
  localparam logic [OP_W-1:0] OP_SLEEP   = 2'b00;
  localparam logic [OP_W-1:0] OP_WRITE   = 2'b01;
  localparam logic [OP_W-1:0] OP_COMPUTE = 2'b10;
  localparam logic [OP_W-1:0] OP_READ    = 2'b11;

  localparam int ID_W     = 8;   // layer id
  localparam int ROW_W    = 4;   // row index
  localparam int THR_W    = 4;   // sign-magnitude, msb is sign
  localparam int COLS     = 4;   // columns per crossbar group
  localparam int SUM_BITS = 3;   // bits per column sum, also plane count
  localparam int SEL_W    = 2;

  // crossbar select for READ, other codes read as zero
  localparam logic [SEL_W-1:0] SEL_POS = 2'd0;
  localparam logic [SEL_W-1:0] SEL_NEG = 2'd1;

  localparam int CSUM_W = COLS * SUM_BITS;

  // one word, two decodings
  // flat: plane p of column c sits at bit c*SUM_BITS+p (crossbar interleave)
  // cols: unsigned per-column sums for the arithmetic
  typedef union packed {
    logic [CSUM_W-1:0]                flat;
    logic [COLS-1:0][SUM_BITS-1:0]    cols;
  } colsum_u;

endpackage

`default_nettype wire
